// File: hdl/bp_activation_ram.sv
`timescale 1ns/1ns
`default_nettype none

module bp_activation_ram (
	input  wire               clk,
	input  wire               rst_n,
	input  wire               i_we,
	input  wire bp_pkg::idx_t i_widx,
	input  wire bp_pkg::fx_t  i_wdata,
	input  wire bp_pkg::idx_t i_aidx,
	output bp_pkg::fx_t       o_adata,
	input  wire               i_rd_en,
	input  wire bp_pkg::idx_t i_rd_idx,
	output bp_pkg::fx_t       o_rd_data,
	output logic              o_rd_valid
);
	import bp_pkg::*;

	fx_t mem [NUM_HIDDEN];

	assign o_adata = mem[i_aidx];                    // APB side read

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int k = 0; k < NUM_HIDDEN; k++)
				mem[k] <= '0;
			o_rd_valid <= 1'b0;
		end else begin
			if (i_we)
				mem[i_widx] <= i_wdata;
			o_rd_valid <= i_rd_en;
		end
	end

	// Engine port registered for one cycle of latency
	always_ff @(posedge clk) begin
		if (i_rd_en)
			o_rd_data <= mem[i_rd_idx];
	end

endmodule

`default_nettype wire

// File: hdl/bp_apb_regs.sv
`timescale 1ns/1ns
`default_nettype none

module bp_apb_regs (
	input  wire                clk,
	input  wire                rst_n,
	input  wire                i_psel,
	input  wire                i_penable,
	input  wire                i_pwrite,
	input  wire bp_pkg::apb_addr_t i_paddr,
	input  wire bp_pkg::apb_data_t i_pwdata,
	output bp_pkg::apb_data_t  o_prdata,
	output logic               o_pready,
	output logic               o_pslverr,
	bp_ctrl_if.regs            ctrl,
	output logic               o_act_we,
	output bp_pkg::idx_t       o_act_idx,
	output bp_pkg::fx_t        o_act_wdata,
	input  wire bp_pkg::fx_t   i_act_rdata,
	output bp_pkg::idx_t       o_res_idx,
	input  wire bp_pkg::fx_t   i_grad_rdata,
	input  wire bp_pkg::fx_t   i_upd_rdata
);
	import bp_pkg::*;

	logic access;
	logic sel_ctrl;
	logic sel_status;
	logic sel_target;
	logic sel_output;
	logic sel_delta;
	logic sel_act;
	logic sel_grad;
	logic sel_upd;
	logic mapped;
	logic read_only;
	logic busy_block;
	logic wr_ok;
	fx_t  target_q;
	fx_t  node_out_q;
	logic done_q;

	function automatic apb_data_t sext(fx_t v);
		return {{(APB_DATA_W-FX_W){v[FX_W-1]}}, v};
	endfunction

	assign access     = i_psel && i_penable;
	assign sel_ctrl   = (i_paddr == REG_CTRL);
	assign sel_status = (i_paddr == REG_STATUS);
	assign sel_target = (i_paddr == REG_TARGET);
	assign sel_output = (i_paddr == REG_OUTPUT);
	assign sel_delta  = (i_paddr == REG_DELTA);
	assign sel_act    = (i_paddr[7:5] == BASE_ACT[7:5]) && (i_paddr[1:0] == 2'b00);
	assign sel_grad   = (i_paddr[7:5] == BASE_GRAD[7:5]) && (i_paddr[1:0] == 2'b00);
	assign sel_upd    = (i_paddr[7:5] == BASE_UPD[7:5]) && (i_paddr[1:0] == 2'b00);

	assign mapped     = sel_ctrl || sel_status || sel_target || sel_output || sel_delta ||
	                    sel_act || sel_grad || sel_upd;
	assign read_only  = sel_status || sel_delta || sel_grad || sel_upd;
	assign busy_block = ctrl.busy && (sel_target || sel_output || sel_act);  // Operands frozen

	assign o_pready  = 1'b1;                                     // Zero wait states
	assign o_pslverr = access && (!mapped || (i_pwrite && (read_only || busy_block)));
	assign wr_ok     = access && i_pwrite && !o_pslverr;

	assign ctrl.start    = wr_ok && sel_ctrl && i_pwdata[0] && !ctrl.busy;
	assign ctrl.target   = target_q;
	assign ctrl.node_out = node_out_q;

	assign o_act_we    = wr_ok && sel_act;
	assign o_act_idx   = idx_t'(i_paddr[4:2]);
	assign o_act_wdata = fx_t'(i_pwdata[FX_W-1:0]);
	assign o_res_idx   = idx_t'(i_paddr[4:2]);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			target_q   <= '0;
			node_out_q <= '0;
			done_q     <= 1'b0;
		end else begin
			if (wr_ok && sel_target)
				target_q <= fx_t'(i_pwdata[FX_W-1:0]);
			if (wr_ok && sel_output)
				node_out_q <= fx_t'(i_pwdata[FX_W-1:0]);
			if (ctrl.start)
				done_q <= 1'b0;
			else if (ctrl.done_pulse)
				done_q <= 1'b1;                                  // Sticky until next run
		end
	end

	always_comb begin
		o_prdata = '0;
		if (sel_status)
			o_prdata = apb_data_t'({done_q, ctrl.busy});
		else if (sel_target)
			o_prdata = sext(target_q);
		else if (sel_output)
			o_prdata = sext(node_out_q);
		else if (sel_delta)
			o_prdata = sext(ctrl.delta);
		else if (sel_act)
			o_prdata = sext(i_act_rdata);
		else if (sel_grad)
			o_prdata = sext(i_grad_rdata);
		else if (sel_upd)
			o_prdata = sext(i_upd_rdata);
	end

	// Error only in an access phase that follows its setup phase
	a_err_in_access: assert property (@(posedge clk) disable iff (!rst_n)
		o_pslverr |-> $past(i_psel && !i_penable));

endmodule

`default_nettype wire

// File: hdl/bp_ctrl_if.sv
`timescale 1ns/1ns
`default_nettype none

interface bp_ctrl_if;
	import bp_pkg::*;

	logic start;                 // One-cycle launch request
	fx_t  target;
	fx_t  node_out;
	logic busy;
	logic done_pulse;
	fx_t  delta;                 // Latched output delta

	modport regs (
		output start, target, node_out,
		input  busy, done_pulse, delta
	);

	modport seq (
		input  start, target, node_out,
		output busy, done_pulse, delta
	);

endinterface

`default_nettype wire

// File: hdl/bp_node_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module bp_node_sequencer (
	input  wire               clk,
	input  wire               rst_n,
	bp_ctrl_if.seq            ctrl,
	output logic              o_delta_go,
	input  wire               i_delta_valid,
	input  wire bp_pkg::fx_t  i_delta,
	output logic              o_rd_en,
	output bp_pkg::idx_t      o_rd_idx,
	input  wire               i_last_written,
	output logic              o_irq
);
	import bp_pkg::*;

	seq_state_e state_q;
	idx_t       idx_q;
	logic       busy_q;
	logic       done_q;
	fx_t        delta_q;

	assign o_delta_go = (state_q == SEQ_IDLE) && ctrl.start;   // Operands already stable
	assign o_rd_en    = (state_q == SEQ_STREAM);
	assign o_rd_idx   = idx_q;

	assign ctrl.busy       = busy_q;
	assign ctrl.done_pulse = done_q;
	assign ctrl.delta      = delta_q;
	assign o_irq           = done_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= SEQ_IDLE;
			idx_q   <= '0;
			busy_q  <= 1'b0;
			done_q  <= 1'b0;
			delta_q <= '0;
		end else begin
			done_q <= 1'b0;
			case (state_q)
				SEQ_IDLE: begin
					if (ctrl.start) begin
						state_q <= SEQ_DELTA;
						busy_q  <= 1'b1;
					end
				end
				SEQ_DELTA: begin
					if (i_delta_valid) begin
						delta_q <= i_delta;
						idx_q   <= '0;
						state_q <= SEQ_STREAM;
					end
				end
				SEQ_STREAM: begin
					if (idx_q == idx_t'(NUM_HIDDEN - 1)) begin
						idx_q   <= '0;
						state_q <= SEQ_DRAIN;
					end else begin
						idx_q <= idx_q + 1'b1;
					end
				end
				SEQ_DRAIN: begin
					if (i_last_written) begin              // Final result is in the bank
						busy_q  <= 1'b0;
						done_q  <= 1'b1;
						state_q <= SEQ_IDLE;
					end
				end
				default: state_q <= SEQ_IDLE;
			endcase
		end
	end

	// Reads only while a run is active
	a_rd_while_busy: assert property (@(posedge clk) disable iff (!rst_n)
		o_rd_en |-> busy_q);

	// Stream starts at index 0 and steps by one
	a_idx_order: assert property (@(posedge clk) disable iff (!rst_n)
		o_rd_en |-> (o_rd_idx == ($past(o_rd_en) ? idx_t'($past(o_rd_idx) + 1'b1)
		                                         : idx_t'(0))));

endmodule

`default_nettype wire

// File: hdl/bp_output_delta.sv
`timescale 1ns/1ns
`default_nettype none

module bp_output_delta (
	input  wire              clk,
	input  wire              rst_n,
	input  wire              i_go,
	input  wire bp_pkg::fx_t i_target,
	input  wire bp_pkg::fx_t i_node_out,
	output bp_pkg::fx_t      o_delta,
	output logic             o_valid
);
	import bp_pkg::*;

	fx_t  err_q;                 // t - y
	fx_t  deriv_q;               // 1 - y
	fx_t  y_q;
	logic v1_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			v1_q    <= 1'b0;
			o_valid <= 1'b0;
		end else begin
			v1_q    <= i_go;
			o_valid <= v1_q;
		end
	end

	// Stage 1 error and derivative term
	always_ff @(posedge clk) begin
		if (i_go) begin
			err_q   <= fx_sub(i_target, i_node_out);
			deriv_q <= fx_sub(FX_ONE, i_node_out);
			y_q     <= i_node_out;
		end
	end

	// Stage 2 sigmoid derivative applied to the error
	always_ff @(posedge clk) begin
		if (v1_q)
			o_delta <= fx_mul(fx_mul(err_q, y_q), deriv_q);
	end

endmodule

`default_nettype wire

// File: hdl/bp_output_node_top.sv
`timescale 1ns/1ns
`default_nettype none

module bp_output_node_top (
	input  wire                    clk,
	input  wire                    rst_n,
	input  wire                    i_psel,
	input  wire                    i_penable,
	input  wire                    i_pwrite,
	input  wire bp_pkg::apb_addr_t i_paddr,
	input  wire bp_pkg::apb_data_t i_pwdata,
	output bp_pkg::apb_data_t      o_prdata,
	output logic                   o_pready,
	output logic                   o_pslverr,
	output logic                   o_irq
);
	import bp_pkg::*;

	bp_ctrl_if   ctrl_bus ();
	bp_result_if res_bus ();

	logic act_we;
	idx_t act_idx;
	fx_t  act_wdata;
	fx_t  act_rdata;
	idx_t res_idx;
	fx_t  grad_rdata;
	fx_t  upd_rdata;
	logic delta_go;
	logic delta_valid;
	fx_t  delta_val;
	logic rd_en;
	idx_t rd_idx;
	idx_t rd_idx_q;
	fx_t  rd_data;
	logic rd_valid;
	logic last_written;

	// Index follows the one-cycle RAM read
	always_ff @(posedge clk) begin
		if (rd_en)
			rd_idx_q <= rd_idx;
	end

	bp_apb_regs u_regs (
		.clk, .rst_n,
		.i_psel, .i_penable, .i_pwrite, .i_paddr, .i_pwdata,
		.o_prdata, .o_pready, .o_pslverr,
		.ctrl         (ctrl_bus.regs),
		.o_act_we     (act_we),
		.o_act_idx    (act_idx),
		.o_act_wdata  (act_wdata),
		.i_act_rdata  (act_rdata),
		.o_res_idx    (res_idx),
		.i_grad_rdata (grad_rdata),
		.i_upd_rdata  (upd_rdata)
	);

	bp_activation_ram u_act_ram (
		.clk, .rst_n,
		.i_we       (act_we),
		.i_widx     (act_idx),
		.i_wdata    (act_wdata),
		.i_aidx     (act_idx),
		.o_adata    (act_rdata),
		.i_rd_en    (rd_en),
		.i_rd_idx   (rd_idx),
		.o_rd_data  (rd_data),
		.o_rd_valid (rd_valid)
	);

	bp_node_sequencer u_seq (
		.clk, .rst_n,
		.ctrl           (ctrl_bus.seq),
		.o_delta_go     (delta_go),
		.i_delta_valid  (delta_valid),
		.i_delta        (delta_val),
		.o_rd_en        (rd_en),
		.o_rd_idx       (rd_idx),
		.i_last_written (last_written),
		.o_irq
	);

	bp_output_delta u_delta (
		.clk, .rst_n,
		.i_go       (delta_go),
		.i_target   (ctrl_bus.target),
		.i_node_out (ctrl_bus.node_out),
		.o_delta    (delta_val),
		.o_valid    (delta_valid)
	);

	bp_point_update u_point (
		.clk, .rst_n,
		.i_valid        (rd_valid),
		.i_idx          (rd_idx_q),
		.i_act          (rd_data),
		.i_delta        (ctrl_bus.delta),
		.res            (res_bus.src),
		.o_last_written (last_written)
	);

	bp_result_bank u_bank (
		.clk, .rst_n,
		.res    (res_bus.dst),
		.i_idx  (res_idx),
		.o_grad (grad_rdata),
		.o_upd  (upd_rdata)
	);

endmodule

`default_nettype wire

// File: hdl/bp_pkg.sv
`default_nettype none

package bp_pkg;

	localparam int FX_W       = 16;
	localparam int FX_FRAC    = 8;                    // Q8.8
	localparam int NUM_HIDDEN = 8;
	localparam int IDX_W      = $clog2(NUM_HIDDEN);
	localparam int APB_ADDR_W = 8;
	localparam int APB_DATA_W = 32;

	typedef logic signed [FX_W-1:0] fx_t;
	typedef logic [IDX_W-1:0]       idx_t;
	typedef logic [APB_ADDR_W-1:0]  apb_addr_t;
	typedef logic [APB_DATA_W-1:0]  apb_data_t;

	localparam fx_t ALPHA_FX = 16'h001A;              // Learning rate 0.1
	localparam fx_t FX_ONE   = 16'h0100;
	localparam fx_t FX_MAX   = 16'h7FFF;
	localparam fx_t FX_MIN   = 16'h8000;

	localparam apb_addr_t REG_CTRL   = 8'h00;
	localparam apb_addr_t REG_STATUS = 8'h04;
	localparam apb_addr_t REG_TARGET = 8'h08;
	localparam apb_addr_t REG_OUTPUT = 8'h0C;
	localparam apb_addr_t REG_DELTA  = 8'h10;
	localparam apb_addr_t BASE_ACT   = 8'h40;
	localparam apb_addr_t BASE_GRAD  = 8'h80;
	localparam apb_addr_t BASE_UPD   = 8'hC0;

	typedef enum logic [1:0] {
		SEQ_IDLE,
		SEQ_DELTA,
		SEQ_STREAM,
		SEQ_DRAIN
	} seq_state_e;

	// Q8.8 product, rescaled and clamped to the 16-bit range
	function automatic fx_t fx_mul(fx_t a, fx_t b);
		logic signed [2*FX_W-1:0] prod;
		logic signed [2*FX_W-1:0] shifted;
		prod    = a * b;
		shifted = prod >>> FX_FRAC;
		if (shifted > 32'sh0000_7FFF)
			return FX_MAX;
		if (shifted < -32'sh0000_8000)
			return FX_MIN;
		return fx_t'(shifted[FX_W-1:0]);
	endfunction

	function automatic fx_t fx_sub(fx_t a, fx_t b);
		logic signed [FX_W:0] diff;
		diff = {a[FX_W-1], a} - {b[FX_W-1], b};
		if (diff[FX_W] != diff[FX_W-1])             // Overflow when top bits disagree
			return diff[FX_W] ? FX_MIN : FX_MAX;
		return fx_t'(diff[FX_W-1:0]);
	endfunction

endpackage

`default_nettype wire

// File: hdl/bp_point_update.sv
`timescale 1ns/1ns
`default_nettype none

module bp_point_update (
	input  wire               clk,
	input  wire               rst_n,
	input  wire               i_valid,
	input  wire bp_pkg::idx_t i_idx,
	input  wire bp_pkg::fx_t  i_act,
	input  wire bp_pkg::fx_t  i_delta,
	bp_result_if.src          res,
	output logic              o_last_written
);
	import bp_pkg::*;

	logic v1_q;
	idx_t idx1_q;
	fx_t  grad1_q;
	logic v2_q;
	idx_t idx2_q;
	fx_t  grad2_q;
	fx_t  upd2_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			v1_q <= 1'b0;
			v2_q <= 1'b0;
		end else begin
			v1_q <= i_valid;
			v2_q <= v1_q;
		end
	end

	// Stage 1 gradient delta * h_j
	always_ff @(posedge clk) begin
		if (i_valid) begin
			grad1_q <= fx_mul(i_delta, i_act);
			idx1_q  <= i_idx;
		end
	end

	// Stage 2 scaled weight update
	always_ff @(posedge clk) begin
		if (v1_q) begin
			upd2_q  <= fx_mul(ALPHA_FX, grad1_q);
			grad2_q <= grad1_q;
			idx2_q  <= idx1_q;
		end
	end

	assign res.wr_en   = v2_q;
	assign res.wr_idx  = idx2_q;
	assign res.wr_grad = grad2_q;
	assign res.wr_upd  = upd2_q;

	assign o_last_written = v2_q && (idx2_q == idx_t'(NUM_HIDDEN - 1));

endmodule

`default_nettype wire

// File: hdl/bp_result_bank.sv
`timescale 1ns/1ns
`default_nettype none

module bp_result_bank (
	input  wire               clk,
	input  wire               rst_n,
	bp_result_if.dst          res,
	input  wire bp_pkg::idx_t i_idx,
	output bp_pkg::fx_t       o_grad,
	output bp_pkg::fx_t       o_upd
);
	import bp_pkg::*;

	fx_t grad_mem [NUM_HIDDEN];
	fx_t upd_mem  [NUM_HIDDEN];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int k = 0; k < NUM_HIDDEN; k++) begin
				grad_mem[k] <= '0;
				upd_mem[k]  <= '0;
			end
		end else if (res.wr_en) begin
			grad_mem[res.wr_idx] <= res.wr_grad;
			upd_mem[res.wr_idx]  <= res.wr_upd;
		end
	end

	assign o_grad = grad_mem[i_idx];             // APB read path
	assign o_upd  = upd_mem[i_idx];

	// Pipeline stage registers carry no reset, so a write must bring known data
	a_wr_known: assert property (@(posedge clk) disable iff (!rst_n)
		res.wr_en |-> !$isunknown({res.wr_idx, res.wr_grad, res.wr_upd}));

endmodule

`default_nettype wire

// File: hdl/bp_result_if.sv
`timescale 1ns/1ns
`default_nettype none

interface bp_result_if;
	import bp_pkg::*;

	logic wr_en;
	idx_t wr_idx;
	fx_t  wr_grad;
	fx_t  wr_upd;

	// Point pipeline side
	modport src (
		output wr_en, wr_idx, wr_grad, wr_upd
	);

	// Result bank side
	modport dst (
		input  wr_en, wr_idx, wr_grad, wr_upd
	);

endinterface

`default_nettype wire

// File: sim/tb_bp_output_node.sv
`timescale 1ns/1ns
`default_nettype none

module tb_bp_output_node;
	import bp_pkg::*;

	localparam int          CLK_PERIOD = 4;
	localparam int          NUM_RANDOM = 6;
	localparam int          NUM_RUNS   = NUM_RANDOM + 3;        // Directed, random and busy runs
	localparam int          RUN_BOUND  = 200;                   // Cycles per run incl. APB traffic
	localparam int          POLL_LIMIT = 40;
	localparam logic [31:0] SEED       = 32'h4419_1459;

	logic      clk;
	logic      rst_n;
	logic      psel;
	logic      penable;
	logic      pwrite;
	apb_addr_t paddr;
	apb_data_t pwdata;
	apb_data_t prdata;
	logic      pready;
	logic      pslverr;
	logic      irq;
	int        irq_count = 0;
	fx_t       act_vec [NUM_HIDDEN];
	fx_t       exp_delta;
	fx_t       exp_grad [NUM_HIDDEN];
	fx_t       exp_upd  [NUM_HIDDEN];

	bp_output_node_top u_dut (
		.clk       (clk),
		.rst_n     (rst_n),
		.i_psel    (psel),
		.i_penable (penable),
		.i_pwrite  (pwrite),
		.i_paddr   (paddr),
		.i_pwdata  (pwdata),
		.o_prdata  (prdata),
		.o_pready  (pready),
		.o_pslverr (pslverr),
		.o_irq     (irq)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	always @(posedge clk) begin
		if (irq)
			irq_count <= irq_count + 1;
	end

	initial begin
		#((NUM_RUNS + 2) * RUN_BOUND * CLK_PERIOD);
		$display("Test failed");
		$fatal(1, "Watchdog expired before the tests finished");
	end

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
			$display("Test failed");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	function automatic fx_t clamp16(int v);
		if (v > 32767)
			return 16'h7FFF;
		if (v < -32768)
			return 16'h8000;
		return fx_t'(v);
	endfunction

	// Reference Q8.8 arithmetic on plain integers
	function automatic fx_t q88_mul(fx_t a, fx_t b);
		int p;
		p = (int'(a) * int'(b)) >>> 8;
		return clamp16(p);
	endfunction

	function automatic fx_t q88_sub(fx_t a, fx_t b);
		return clamp16(int'(a) - int'(b));
	endfunction

	function automatic apb_data_t widen(fx_t v);
		return apb_data_t'(int'(v));                         // Sign-extended read value
	endfunction

	// One in four operands is an edge value that drives saturation
	function automatic fx_t pick_fx();
		if ($urandom % 4 == 0) begin
			case ($urandom % 4)
				0: return 16'h7FFF;
				1: return 16'h8000;
				2: return 16'h0100;
				default: return 16'hFF00;
			endcase
		end
		return fx_t'($urandom);
	endfunction

	// Starts 1 ns after a rising edge and returns at the same point two cycles later
	task automatic apb_xfer(input logic write, input apb_addr_t addr, input apb_data_t wdata,
		output apb_data_t rdata, output logic err);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = write;
		paddr   = addr;
		pwdata  = wdata;
		@(posedge clk);
		#1;
		penable = 1'b1;
		#1;
		rdata = prdata;
		err   = pslverr;
		check_value("pready", pready, 1);
		@(posedge clk);
		#1;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
		apb_data_t rd;
		logic      err;
		apb_xfer(1'b1, addr, data, rd, err);
		check_value($sformatf("pslverr on write to 0x%02h", addr), err, 0);
	endtask

	task automatic apb_write_err(input apb_addr_t addr, input apb_data_t data);
		apb_data_t rd;
		logic      err;
		apb_xfer(1'b1, addr, data, rd, err);
		check_value($sformatf("pslverr on write to 0x%02h", addr), err, 1);
	endtask

	task automatic read_expect(input apb_addr_t addr, input apb_data_t exp, input string name);
		apb_data_t rd;
		logic      err;
		apb_xfer(1'b0, addr, '0, rd, err);
		check_value($sformatf("pslverr on read of 0x%02h", addr), err, 0);
		check_value(name, rd, exp);
	endtask

	task automatic read_err(input apb_addr_t addr);
		apb_data_t rd;
		logic      err;
		apb_xfer(1'b0, addr, '0, rd, err);
		check_value($sformatf("pslverr on read of 0x%02h", addr), err, 1);
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) @(posedge clk);
		#1;
	endtask

	task automatic wait_done();
		apb_data_t rd;
		logic      err;
		int        polls;
		polls = 0;
		do begin
			if (polls == POLL_LIMIT) begin
				$display("Test failed");
				$fatal(1, "Done bit not set after %0d status polls", POLL_LIMIT);
			end
			apb_xfer(1'b0, REG_STATUS, '0, rd, err);
			polls++;
		end while (!rd[1]);
	endtask

	task automatic model_results(input fx_t t, input fx_t y);
		fx_t err;
		fx_t deriv;
		err       = q88_sub(t, y);
		deriv     = q88_sub(FX_ONE, y);                      // Sigmoid derivative y(1-y)
		exp_delta = q88_mul(q88_mul(err, y), deriv);
		for (int j = 0; j < NUM_HIDDEN; j++) begin
			exp_grad[j] = q88_mul(exp_delta, act_vec[j]);
			exp_upd[j]  = q88_mul(ALPHA_FX, exp_grad[j]);
		end
	endtask

	task automatic load_operands(input fx_t t, input fx_t y);
		apb_write(REG_TARGET, widen(t));
		apb_write(REG_OUTPUT, widen(y));
		for (int j = 0; j < NUM_HIDDEN; j++)
			apb_write(apb_addr_t'(BASE_ACT + 4 * j), widen(act_vec[j]));
	endtask

	task automatic check_results();
		read_expect(REG_DELTA, widen(exp_delta), "DELTA");
		for (int j = 0; j < NUM_HIDDEN; j++) begin
			read_expect(apb_addr_t'(BASE_GRAD + 4 * j), widen(exp_grad[j]),
				$sformatf("GRAD[%0d]", j));
			read_expect(apb_addr_t'(BASE_UPD + 4 * j), widen(exp_upd[j]),
				$sformatf("UPD[%0d]", j));
		end
	endtask

	task automatic run_compute(input fx_t t, input fx_t y);
		int irq_before;
		irq_before = irq_count;
		load_operands(t, y);
		model_results(t, y);
		apb_write(REG_CTRL, 1);
		wait_done();
		check_value("irq pulses", irq_count - irq_before, 1);
		read_expect(REG_STATUS, 2, "STATUS");
		check_results();
	endtask

	task automatic reset_state();
		check_value("o_irq", irq, 0);
		read_expect(REG_STATUS, 0, "STATUS");
		read_expect(REG_DELTA, 0, "DELTA");
		for (int j = 0; j < NUM_HIDDEN; j++) begin
			read_expect(apb_addr_t'(BASE_GRAD + 4 * j), 0, $sformatf("GRAD[%0d]", j));
			read_expect(apb_addr_t'(BASE_UPD + 4 * j), 0, $sformatf("UPD[%0d]", j));
			read_expect(apb_addr_t'(BASE_ACT + 4 * j), 0, $sformatf("ACT[%0d]", j));
		end
	endtask

	task automatic register_access();
		apb_addr_t addr;
		for (int j = 0; j < NUM_HIDDEN; j++) begin
			addr       = apb_addr_t'(BASE_ACT + 4 * j);
			act_vec[j] = {~addr, addr};                      // Pattern tied to the full address
			apb_write(addr, widen(act_vec[j]));
		end
		for (int j = 0; j < NUM_HIDDEN; j++)
			read_expect(apb_addr_t'(BASE_ACT + 4 * j), widen(act_vec[j]),
				$sformatf("ACT[%0d]", j));
		apb_write(REG_TARGET, 32'h0000_FE80);
		read_expect(REG_TARGET, 32'hFFFF_FE80, "TARGET");
		apb_write(REG_OUTPUT, 32'h0000_00C0);
		read_expect(REG_OUTPUT, 32'h0000_00C0, "OUTPUT");
		apb_write_err(8'h14, 32'h0000_5555);
		apb_write_err(8'h20, 32'h0000_5555);
		apb_write_err(8'h3C, 32'h0000_5555);
		apb_write_err(8'h42, 32'h0000_5555);                 // Misaligned activation
		read_err(8'h14);
		read_err(8'h81);
		apb_write_err(REG_STATUS, 32'h0000_0003);
		apb_write_err(REG_DELTA, 32'h0000_1234);
		apb_write_err(BASE_GRAD, 32'h0000_1234);
		apb_write_err(apb_addr_t'(BASE_UPD + 4), 32'h0000_1234);
		read_expect(REG_STATUS, 0, "STATUS");
		read_expect(REG_DELTA, 0, "DELTA");
		read_expect(BASE_GRAD, 0, "GRAD[0]");
		read_expect(apb_addr_t'(BASE_UPD + 4), 0, "UPD[1]");
		read_expect(REG_TARGET, 32'hFFFF_FE80, "TARGET");
		read_expect(REG_OUTPUT, 32'h0000_00C0, "OUTPUT");
		read_expect(BASE_ACT, widen(act_vec[0]), "ACT[0]");
		check_value("irq pulses", irq_count, 0);
	endtask

	task automatic directed_compute();
		act_vec = '{16'h0080, 16'h0100, 16'hFF80, 16'h0200,
		            16'h0000, 16'h7FFF, 16'h8000, 16'h0040};
		run_compute(16'h0100, 16'h00C0);                     // t = 1.0, y = 0.75
	endtask

	task automatic random_computes();
		fx_t t;
		fx_t y;
		for (int r = 0; r < NUM_RANDOM; r++) begin
			t = pick_fx();
			y = pick_fx();
			for (int j = 0; j < NUM_HIDDEN; j++)
				act_vec[j] = pick_fx();
			run_compute(t, y);
		end
	endtask

	task automatic busy_behavior();
		fx_t t;
		fx_t y;
		int  irq_before;
		t = 16'h0180;
		y = 16'h00A0;
		for (int j = 0; j < NUM_HIDDEN; j++)
			act_vec[j] = pick_fx();
		load_operands(t, y);
		model_results(t, y);
		irq_before = irq_count;
		apb_write(REG_CTRL, 1);
		apb_write_err(REG_TARGET, 32'h0000_1111);
		apb_write_err(REG_OUTPUT, 32'h0000_2222);
		apb_write_err(apb_addr_t'(BASE_ACT + 12), 32'h0000_3333);
		apb_write(REG_CTRL, 1);                              // Ignored while busy
		wait_done();
		idle_cycles(4 * NUM_HIDDEN);
		check_value("irq pulses", irq_count - irq_before, 1);
		read_expect(REG_TARGET, widen(t), "TARGET");
		read_expect(REG_OUTPUT, widen(y), "OUTPUT");
		read_expect(apb_addr_t'(BASE_ACT + 12), widen(act_vec[3]), "ACT[3]");
		check_results();
		read_expect(REG_STATUS, 2, "STATUS");                // Done is sticky
		apb_write(REG_CTRL, 1);
		read_expect(REG_STATUS, 1, "STATUS");                // New start clears done
		wait_done();
		check_value("irq pulses", irq_count - irq_before, 2);
		check_results();
	endtask

	initial begin
		void'($urandom(SEED));
		clk     = 1'b0;
		rst_n   = 1'b0;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = '0;
		pwdata  = '0;
		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;
		reset_state();
		register_access();
		directed_compute();
		random_computes();
		busy_behavior();
		$display("Test passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: tb.f
hdl/bp_pkg.sv
hdl/bp_ctrl_if.sv
hdl/bp_result_if.sv
hdl/bp_apb_regs.sv
hdl/bp_activation_ram.sv
hdl/bp_node_sequencer.sv
hdl/bp_output_delta.sv
hdl/bp_point_update.sv
hdl/bp_result_bank.sv
hdl/bp_output_node_top.sv
sim/tb_bp_output_node.sv
